// File: async_fifo.f
source/fifo_pkg.sv
source/dual_port_ram.sv
source/gray_ptr_sync.sv
source/wr_ptr_ctrl.sv
source/rd_ptr_ctrl.sv
source/async_fifo.sv
verification/fifo_monitor.sv
verification/async_fifo_asserts.sv
verification/async_fifo_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the async FIFO testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --timescale 1ns/1ps \
  --top-module async_fifo_tb \
  -f async_fifo.f \
  -o Vasync_fifo_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# Keep running past assertion errors so the testbench can summarize.
./obj_dir/Vasync_fifo_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
  exit 1
fi
exit 0

// File: verification/async_fifo_tb.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_tb;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_CONC, OP_IDLE} op_e;

  typedef struct packed {
    op_e op;
    int  count;  // Words, or cycles for idle and concurrent rows.
    int  occ;    // Occupancy after the row, -1 if random.
  } stim_row_t;

  logic                            wr_clk;
  logic                            rd_clk;
  logic                            wr_rst_n;
  logic                            rd_rst_n;
  fifo_pkg::fifo_wr_req_t          wr_req;
  logic                            rd_en;
  fifo_pkg::fifo_wr_status_t       wr_status;
  logic [fifo_pkg::DATA_WIDTH-1:0] rd_data;
  fifo_pkg::fifo_rd_status_t       rd_status;
  int                              mon_errors;
  int                              seed;

  // ************************************************************
  // Stimulus table
  // ************************************************************
  string row_name [14] = '{
    "reset_flags", "fill_over", "full_settle", "drain_13", "three_left",
    "read_one", "two_left", "drain_past", "empty_settle", "write_12",
    "afull_settle", "concurrent", "flush", "final_settle"
  };

  stim_row_t rows [14] = '{
    '{OP_IDLE,   8,  0}, '{OP_WRITE, 20, 16}, '{OP_IDLE,  8, 16},
    '{OP_READ,  13,  3}, '{OP_IDLE,   8,  3}, '{OP_READ,  1,  2},
    '{OP_IDLE,   8,  2}, '{OP_READ,   6,  0}, '{OP_IDLE,  8,  0},
    '{OP_WRITE, 12, 12}, '{OP_IDLE,   8, 12}, '{OP_CONC, 60, -1},
    '{OP_READ,  24,  0}, '{OP_IDLE,   8,  0}
  };

  async_fifo u_async_fifo (
    .wr_clk    (wr_clk),
    .wr_rst_n  (wr_rst_n),
    .wr_req    (wr_req),
    .rd_clk    (rd_clk),
    .rd_rst_n  (rd_rst_n),
    .rd_en     (rd_en),
    .wr_status (wr_status),
    .rd_data   (rd_data),
    .rd_status (rd_status)
  );

  fifo_monitor u_monitor (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .wr_req      (wr_req),
    .wr_status   (wr_status),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .rd_status   (rd_status),
    .error_count (mon_errors)
  );

  initial begin
    rd_clk = 1'b0;
    forever #50 rd_clk = ~rd_clk;  // 100 ns.
  end

  initial begin
    wr_clk = 1'b0;
    forever #35 wr_clk = ~wr_clk;  // 70 ns, unrelated to rd_clk.
  end

  // ************************************************************
  // Stimulus tasks
  // ************************************************************
  task automatic write_burst(input int n);
    int r;
    repeat (n) begin
      @(negedge wr_clk);
      r           = $random(seed);
      wr_req.en   = 1'b1;
      wr_req.data = r[fifo_pkg::DATA_WIDTH-1:0];
    end
    @(negedge wr_clk);
    wr_req.en = 1'b0;
  endtask

  task automatic read_burst(input int n);
    repeat (n) begin
      @(negedge rd_clk);
      rd_en = 1'b1;
    end
    @(negedge rd_clk);
    rd_en = 1'b0;
  endtask

  task automatic run_concurrent(input int n);
    int wr_r;
    int rd_r;
    fork
      begin
        repeat (n) begin
          @(negedge wr_clk);
          wr_r        = $random(seed);
          wr_req.en   = wr_r[9];
          wr_req.data = wr_r[fifo_pkg::DATA_WIDTH-1:0];
        end
        @(negedge wr_clk);
        wr_req.en = 1'b0;
      end
      begin
        repeat (n) begin
          @(negedge rd_clk);
          rd_r  = $random(seed);
          rd_en = rd_r[5];
        end
        @(negedge rd_clk);
        rd_en = 1'b0;
      end
    join
  endtask

  // Lets the pointer crossings and flags settle.
  task automatic idle_wait(input int n);
    fork
      repeat (n) @(negedge rd_clk);
      repeat (n) @(negedge wr_clk);
    join
  endtask

  // ************************************************************
  // Main sequence
  // ************************************************************
  initial begin : stimulus
    int assert_fails;
    seed     = 32'ha134;
    wr_rst_n = 1'b0;
    rd_rst_n = 1'b0;
    wr_req   = '0;
    rd_en    = 1'b0;
    repeat (4) @(negedge rd_clk);
    wr_rst_n = 1'b1;
    rd_rst_n = 1'b1;

    foreach (rows[i]) begin
      u_monitor.start_row(row_name[i]);
      case (rows[i].op)
        OP_WRITE: write_burst(rows[i].count);
        OP_READ:  read_burst(rows[i].count);
        OP_CONC:  run_concurrent(rows[i].count);
        default:  idle_wait(rows[i].count);
      endcase
      @(negedge rd_clk);  // Last read word comes out.
      u_monitor.end_row(rows[i].op == OP_IDLE, rows[i].occ);
    end

    assert_fails = u_async_fifo.u_asserts.wr_fails + u_async_fifo.u_asserts.rd_fails;
    u_monitor.print_summary(assert_fails);
    if (mon_errors == 0 && assert_fails == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    int total;
    total = 0;
    foreach (rows[i]) total += rows[i].count;
    #((total * 4 + 50) * 100);
    $display("Timeout: run still busy after %0d rd_clk periods", total * 4 + 50);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/async_fifo_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo_asserts (
  input logic                           wr_clk,
  input logic                           wr_rst_n,
  input logic                           rd_clk,
  input logic                           rd_rst_n,
  input logic                           ram_wr_en,
  input logic                           ram_rd_en,
  input fifo_pkg::fifo_rd_status_t      rd_status,
  input logic [fifo_pkg::PTR_WIDTH-1:0] wr_ptr_gray,
  input logic [fifo_pkg::PTR_WIDTH-1:0] rd_ptr_gray,
  input logic [fifo_pkg::PTR_WIDTH-1:0] wr_ptr_bin_rd,
  input logic [fifo_pkg::PTR_WIDTH-1:0] rd_ptr_bin_wr
);

  int wr_fails = 0;  // Per domain.
  int rd_fails = 0;

  logic [fifo_pkg::PTR_WIDTH-1:0] wr_used;  // Occupancy seen by the writer.
  logic [fifo_pkg::PTR_WIDTH-1:0] rd_used;  // Occupancy seen by the reader.

  // Prefix XOR from the top bit down.
  function automatic logic [fifo_pkg::PTR_WIDTH-1:0] gray_to_bin(
    input logic [fifo_pkg::PTR_WIDTH-1:0] gray
  );
    logic [fifo_pkg::PTR_WIDTH-1:0] bin;
    bin[fifo_pkg::PTR_WIDTH-1] = gray[fifo_pkg::PTR_WIDTH-1];
    for (int i = fifo_pkg::PTR_WIDTH - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

  assign wr_used = gray_to_bin(wr_ptr_gray) - rd_ptr_bin_wr;
  assign rd_used = wr_ptr_bin_rd - gray_to_bin(rd_ptr_gray);

  // ************************************************************
  // Write domain
  // ************************************************************
  no_write_while_full : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
      ram_wr_en |-> (wr_used < fifo_pkg::FIFO_DEPTH)
  ) else begin
    wr_fails++;
    $error("RAM write while full");
  end

  wr_gray_one_bit : assert property (
    @(posedge wr_clk) disable iff (!wr_rst_n)
      $countones(wr_ptr_gray ^ $past(wr_ptr_gray)) <= 1
  ) else begin
    wr_fails++;
    $error("Write Gray pointer changed in more than one bit");
  end

  // ************************************************************
  // Read domain
  // ************************************************************
  no_read_while_empty : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      ram_rd_en |-> (rd_used != '0)
  ) else begin
    rd_fails++;
    $error("RAM read while empty");
  end

  // Valid follows each step of the read pointer.
  valid_after_read : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      rd_status.valid == (rd_ptr_gray != $past(rd_ptr_gray))
  ) else begin
    rd_fails++;
    $error("Read valid not one cycle after an accepted read");
  end

  rd_gray_one_bit : assert property (
    @(posedge rd_clk) disable iff (!rd_rst_n)
      $countones(rd_ptr_gray ^ $past(rd_ptr_gray)) <= 1
  ) else begin
    rd_fails++;
    $error("Read Gray pointer changed in more than one bit");
  end

endmodule

bind async_fifo async_fifo_asserts u_asserts (
  .wr_clk        (wr_clk),
  .wr_rst_n      (wr_rst_n),
  .rd_clk        (rd_clk),
  .rd_rst_n      (rd_rst_n),
  .ram_wr_en     (ram_wr_en),
  .ram_rd_en     (ram_rd_en),
  .rd_status     (rd_status),
  .wr_ptr_gray   (wr_ptr_gray),
  .rd_ptr_gray   (rd_ptr_gray),
  .wr_ptr_bin_rd (wr_ptr_bin_rd),
  .rd_ptr_bin_wr (rd_ptr_bin_wr)
);

`default_nettype wire

// File: verification/fifo_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module fifo_monitor (
  input  logic                            wr_clk,
  input  logic                            wr_rst_n,
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  fifo_pkg::fifo_wr_req_t          wr_req,
  input  fifo_pkg::fifo_wr_status_t       wr_status,
  input  logic                            rd_en,
  input  logic [fifo_pkg::DATA_WIDTH-1:0] rd_data,
  input  fifo_pkg::fifo_rd_status_t       rd_status,
  output int                              error_count
);

  logic [fifo_pkg::DATA_WIDTH-1:0] ref_q [$];
  logic [fifo_pkg::DATA_WIDTH-1:0] exp_word;
  logic                            read_pending = 1'b0;
  string                           cur_test = "reset";
  int                              rd_errors = 0;
  int                              chk_errors = 0;
  int                              row_start_errors = 0;
  int                              rows_passed = 0;
  int                              rows_failed = 0;

  assign error_count = rd_errors + chk_errors;

  // ************************************************************
  // Reference queue
  // ************************************************************
  always @(posedge wr_clk) begin
    if (wr_rst_n && wr_req.en && !wr_status.full) begin
      ref_q.push_back(wr_req.data);
    end
  end

  // Word of the read accepted one edge ago is checked here.
  always @(posedge rd_clk) begin
    if (rd_rst_n) begin
      if (rd_status.valid) begin
        if (!read_pending) begin
          $display("%s: valid pulse without an accepted read", cur_test);
          rd_errors++;
        end else if (rd_data !== exp_word) begin
          $display("Mismatch %s: rd_data expected 0x%h actual 0x%h",
                   cur_test, exp_word, rd_data);
          rd_errors++;
        end
      end else if (read_pending) begin
        $display("%s: accepted read produced no valid word", cur_test);
        rd_errors++;
      end
      read_pending = 1'b0;
      if (rd_en && !rd_status.empty) begin
        if (ref_q.size() == 0) begin
          $display("%s: read accepted although nothing was written", cur_test);
          rd_errors++;
        end else begin
          exp_word     = ref_q.pop_front();
          read_pending = 1'b1;
        end
      end
    end
  end

  // ************************************************************
  // Row control, called from the testbench
  // ************************************************************
  task automatic check_value(input string what, input int exp_val, input int act_val);
    if (act_val != exp_val) begin
      $display("Mismatch %s: %s expected %0d actual %0d", cur_test, what, exp_val, act_val);
      chk_errors++;
    end
  endtask

  task automatic start_row(input string name);
    cur_test         = name;
    row_start_errors = rd_errors + chk_errors;
  endtask

  task automatic end_row(input bit settled, input int occ_exp);
    int occ;
    occ = ref_q.size();
    if (occ_exp >= 0) begin
      check_value("occupancy", occ_exp, occ);
    end
    if (settled) begin
      check_value("full", int'(occ == fifo_pkg::FIFO_DEPTH), int'(wr_status.full));
      check_value("afull", int'(occ >= int'(fifo_pkg::FIFO_AFULL)), int'(wr_status.afull));
      check_value("empty", int'(occ == 0), int'(rd_status.empty));
      check_value("aempty", int'(occ <= int'(fifo_pkg::FIFO_AEMPTY)), int'(rd_status.aempty));
      check_value("valid", 0, int'(rd_status.valid));
    end
    if (rd_errors + chk_errors == row_start_errors) begin
      $display("%-14s pass  (occupancy %0d)", cur_test, occ);
      rows_passed++;
    end else begin
      $display("%-14s fail  (%0d errors)", cur_test, rd_errors + chk_errors - row_start_errors);
      rows_failed++;
    end
  endtask

  task automatic print_summary(input int assert_fails);
    $display("Rows passed: %0d, rows failed: %0d, check errors: %0d, assertion errors: %0d",
             rows_passed, rows_failed, rd_errors + chk_errors, assert_fails);
  endtask

endmodule

`default_nettype wire

// File: source/async_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module async_fifo (
  input  logic                            wr_clk,
  input  logic                            wr_rst_n,
  input  fifo_pkg::fifo_wr_req_t          wr_req,
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            rd_en,
  output fifo_pkg::fifo_wr_status_t       wr_status,
  output logic [fifo_pkg::DATA_WIDTH-1:0] rd_data,
  output fifo_pkg::fifo_rd_status_t       rd_status
);

  logic                            ram_wr_en;
  logic [fifo_pkg::ADDR_WIDTH-1:0] ram_wr_addr;
  logic                            ram_rd_en;
  logic [fifo_pkg::ADDR_WIDTH-1:0] ram_rd_addr;

  logic [fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_gray;
  logic [fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_gray;
  logic [fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_bin_rd;  // Write pointer seen by rd_clk.
  logic [fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_bin_wr;  // Read pointer seen by wr_clk.

  // ************************************************************
  // Write domain
  // ************************************************************
  wr_ptr_ctrl u_wr_ptr_ctrl (
    .wr_clk      (wr_clk),
    .wr_rst_n    (wr_rst_n),
    .wr_req      (wr_req),
    .rd_ptr_bin  (rd_ptr_bin_wr),
    .ram_wr_en   (ram_wr_en),
    .ram_wr_addr (ram_wr_addr),
    .wr_ptr_gray (wr_ptr_gray),
    .wr_status   (wr_status)
  );

  gray_ptr_sync u_rd2wr_sync (
    .dst_clk   (wr_clk),
    .dst_rst_n (wr_rst_n),
    .gray_in   (rd_ptr_gray),
    .bin_out   (rd_ptr_bin_wr)
  );

  // ************************************************************
  // Read domain
  // ************************************************************
  rd_ptr_ctrl u_rd_ptr_ctrl (
    .rd_clk      (rd_clk),
    .rd_rst_n    (rd_rst_n),
    .rd_en       (rd_en),
    .wr_ptr_bin  (wr_ptr_bin_rd),
    .ram_rd_en   (ram_rd_en),
    .ram_rd_addr (ram_rd_addr),
    .rd_ptr_gray (rd_ptr_gray),
    .rd_status   (rd_status)
  );

  gray_ptr_sync u_wr2rd_sync (
    .dst_clk   (rd_clk),
    .dst_rst_n (rd_rst_n),
    .gray_in   (wr_ptr_gray),
    .bin_out   (wr_ptr_bin_rd)
  );

  // Storage shared by both domains.
  dual_port_ram u_ram (
    .wr_clk  (wr_clk),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (wr_req.data),
    .rd_clk  (rd_clk),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (rd_data)
  );

endmodule

`default_nettype wire

// File: source/rd_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module rd_ptr_ctrl (
  input  logic                            rd_clk,
  input  logic                            rd_rst_n,
  input  logic                            rd_en,
  input  logic [fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_bin,
  output logic                            ram_rd_en,
  output logic [fifo_pkg::ADDR_WIDTH-1:0] ram_rd_addr,
  output logic [fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_gray,
  output fifo_pkg::fifo_rd_status_t       rd_status
);

  logic                           rd_vld;
  logic [fifo_pkg::PTR_WIDTH-1:0] rd_ptr;
  logic [fifo_pkg::PTR_WIDTH-1:0] rd_ptr_nxt;
  logic [fifo_pkg::PTR_WIDTH-1:0] rd_gray_nxt;
  logic [fifo_pkg::PTR_WIDTH-1:0] rd_used_nxt;
  logic                           empty_nxt;
  logic                           aempty_nxt;

  // ************************************************************
  // Read acceptance and next pointer
  // ************************************************************
  assign rd_vld = rd_en && !rd_status.empty;  // Reads while empty are ignored.

  assign rd_ptr_nxt  = rd_ptr + {{fifo_pkg::ADDR_WIDTH{1'b0}}, rd_vld};
  assign rd_gray_nxt = (rd_ptr_nxt >> 1) ^ rd_ptr_nxt;

  assign ram_rd_en   = rd_vld;
  assign ram_rd_addr = rd_ptr[fifo_pkg::ADDR_WIDTH-1:0];

  // Empty when both pointers match, wrap bit included.
  assign empty_nxt = (rd_ptr_nxt == wr_ptr_bin);

  // Write pointer lags, so occupancy is never over-reported here.
  assign rd_used_nxt = wr_ptr_bin - rd_ptr_nxt;
  assign aempty_nxt  = (rd_used_nxt <= fifo_pkg::FIFO_AEMPTY);

  // ************************************************************
  // Pointer registers
  // ************************************************************
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_ptr      <= '0;
      rd_ptr_gray <= '0;
    end else begin
      rd_ptr      <= rd_ptr_nxt;
      rd_ptr_gray <= rd_gray_nxt;
    end
  end

  // ************************************************************
  // Status flags and read-data valid
  // ************************************************************
  // Nothing stored after reset.
  always_ff @(posedge rd_clk or negedge rd_rst_n) begin
    if (!rd_rst_n) begin
      rd_status.empty  <= 1'b1;
      rd_status.aempty <= 1'b1;
      rd_status.valid  <= 1'b0;
    end else begin
      rd_status.empty  <= empty_nxt;
      rd_status.aempty <= aempty_nxt;
      rd_status.valid  <= rd_vld;  // RAM output is one cycle behind.
    end
  end

endmodule

`default_nettype wire

// File: source/wr_ptr_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wr_ptr_ctrl (
  input  logic                            wr_clk,
  input  logic                            wr_rst_n,
  input  fifo_pkg::fifo_wr_req_t          wr_req,
  input  logic [fifo_pkg::PTR_WIDTH-1:0]  rd_ptr_bin,
  output logic                            ram_wr_en,
  output logic [fifo_pkg::ADDR_WIDTH-1:0] ram_wr_addr,
  output logic [fifo_pkg::PTR_WIDTH-1:0]  wr_ptr_gray,
  output fifo_pkg::fifo_wr_status_t       wr_status
);

  logic                           wr_vld;
  logic [fifo_pkg::PTR_WIDTH-1:0] wr_ptr;
  logic [fifo_pkg::PTR_WIDTH-1:0] wr_ptr_nxt;
  logic [fifo_pkg::PTR_WIDTH-1:0] wr_gray_nxt;
  logic [fifo_pkg::PTR_WIDTH-1:0] wr_used_nxt;
  logic                           full_nxt;
  logic                           afull_nxt;

  // ************************************************************
  // Write acceptance and next pointer
  // ************************************************************
  assign wr_vld = wr_req.en && !wr_status.full;  // Writes while full are dropped.

  assign wr_ptr_nxt  = wr_ptr + {{fifo_pkg::ADDR_WIDTH{1'b0}}, wr_vld};
  assign wr_gray_nxt = (wr_ptr_nxt >> 1) ^ wr_ptr_nxt;

  assign ram_wr_en   = wr_vld;
  assign ram_wr_addr = wr_ptr[fifo_pkg::ADDR_WIDTH-1:0];

  // Full when the pointers differ only in the wrap bit.
  assign full_nxt = (wr_ptr_nxt == {~rd_ptr_bin[fifo_pkg::PTR_WIDTH-1],
                                    rd_ptr_bin[fifo_pkg::ADDR_WIDTH-1:0]});

  // Read pointer lags, so this never under-reports occupancy.
  assign wr_used_nxt = wr_ptr_nxt - rd_ptr_bin;
  assign afull_nxt   = (wr_used_nxt >= fifo_pkg::FIFO_AFULL);

  // ************************************************************
  // Pointer registers
  // ************************************************************
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_ptr      <= '0;
      wr_ptr_gray <= '0;
    end else begin
      wr_ptr      <= wr_ptr_nxt;
      wr_ptr_gray <= wr_gray_nxt;  // Registered before crossing.
    end
  end

  // ************************************************************
  // Status flags
  // ************************************************************
  always_ff @(posedge wr_clk or negedge wr_rst_n) begin
    if (!wr_rst_n) begin
      wr_status.full  <= 1'b0;
      wr_status.afull <= 1'b0;
    end else begin
      wr_status.full  <= full_nxt;
      wr_status.afull <= afull_nxt;
    end
  end

endmodule

`default_nettype wire

// File: source/gray_ptr_sync.sv
`timescale 1ns/1ps
`default_nettype none

module gray_ptr_sync (
  input  logic                          dst_clk,
  input  logic                          dst_rst_n,
  input  logic [fifo_pkg::PTR_WIDTH-1:0] gray_in,
  output logic [fifo_pkg::PTR_WIDTH-1:0] bin_out
);

  logic [fifo_pkg::PTR_WIDTH-1:0] sync_q1;
  logic [fifo_pkg::PTR_WIDTH-1:0] sync_q2;

  // Two stages in the destination domain.
  always_ff @(posedge dst_clk or negedge dst_rst_n) begin
    if (!dst_rst_n) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= gray_in;  // May go metastable.
      sync_q2 <= sync_q1;
    end
  end

  // Gray to binary. Each bit is the XOR of all Gray bits at or above it.
  always_comb begin
    for (int i = 0; i < fifo_pkg::PTR_WIDTH; i++) begin
      bin_out[i] = ^(sync_q2 >> i);
    end
  end

endmodule

`default_nettype wire

// File: source/dual_port_ram.sv
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram (
  input  logic                           wr_clk,
  input  logic                           wr_en,
  input  logic [fifo_pkg::ADDR_WIDTH-1:0] wr_addr,
  input  logic [fifo_pkg::DATA_WIDTH-1:0] wr_data,
  input  logic                           rd_clk,
  input  logic                           rd_en,
  input  logic [fifo_pkg::ADDR_WIDTH-1:0] rd_addr,
  output logic [fifo_pkg::DATA_WIDTH-1:0] rd_data
);

  logic [fifo_pkg::DATA_WIDTH-1:0] mem [fifo_pkg::FIFO_DEPTH];

  // ************************************************************
  // Write port, wr_clk domain
  // ************************************************************
  always_ff @(posedge wr_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ************************************************************
  // Read port, rd_clk domain
  // ************************************************************
  // Output holds its last word while no read is accepted.
  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: source/fifo_pkg.sv
`default_nettype none

package fifo_pkg;

  // ************************************************************
  // FIFO geometry and thresholds
  // ************************************************************
  localparam int DATA_WIDTH = 8;
  localparam int FIFO_DEPTH = 16;
  localparam int ADDR_WIDTH = 4;
  localparam int PTR_WIDTH  = ADDR_WIDTH + 1;  // Extra wrap bit.

  // Sized to the pointer so occupancy compares stay at one width.
  localparam logic [PTR_WIDTH-1:0] FIFO_AFULL  = PTR_WIDTH'(12);
  localparam logic [PTR_WIDTH-1:0] FIFO_AEMPTY = PTR_WIDTH'(2);

  // ************************************************************
  // Request and status bundles
  // ************************************************************
  typedef struct packed {
    logic                  en;
    logic [DATA_WIDTH-1:0] data;
  } fifo_wr_req_t;

  typedef struct packed {
    logic full;
    logic afull;
  } fifo_wr_status_t;

  typedef struct packed {
    logic empty;
    logic aempty;
    logic valid;  // rd_data holds a fresh word.
  } fifo_rd_status_t;

endpackage

`default_nettype wire
